// File: source/emesh_pkg.sv
//####################
// Mesh transaction types
// Field widths and the shared handshake states
//####################
package emesh_pkg;

   //##################
   // Field widths
   //##################
   localparam int ADDR_W = 32;             // Mesh address bits
   localparam int DATA_W = 32;             // Single data word

   //##################
   // Field types
   //##################
   typedef logic [ADDR_W-1:0] addr_t;      // Dst or src address
   typedef logic [DATA_W-1:0] data_t;      // Write payload
   typedef logic [1:0]        datamode_t;  // Byte, half, word, double

   // Handshake progress of one four-phase cycle
   typedef enum logic [1:0] {
      IDLE      = 2'd0,                    // Nothing pending
      WAIT_ACK  = 2'd1,                    // Req up, ack not seen yet
      WAIT_DROP = 2'd2                     // Ack seen, waiting for release
   } hs_state_t;

endpackage

// File: source/memmap_pkg.sv
//####################
// Address map
// Region and coordinate constants for remap and dispatch
//####################
package memmap_pkg;

   localparam int REGION_W = 4;                  // Top address nibble
   localparam int COORD_W  = 12;                 // Chip row and column

   typedef logic [REGION_W-1:0] region_t;
   typedef logic [COORD_W-1:0]  coord_t;

   localparam region_t VIRT_EXT_MEM = 4'h8;      // Ext mem as the chip sees it
   localparam region_t PHYS_EXT_MEM = 4'h3;      // Real DRAM window
   localparam coord_t  HOST_COORD   = 12'h810;   // Host position on the mesh

   // Host coordinate followed by zero offset bits
   localparam emesh_pkg::addr_t HOST_SRCADDR =
      {HOST_COORD, {(emesh_pkg::ADDR_W-COORD_W){1'b0}}};

   // Region nibble of an address
   function automatic region_t region_of(input emesh_pkg::addr_t addr);
      return addr[emesh_pkg::ADDR_W-1 -: REGION_W];
   endfunction

   // Chip coordinate of an address
   function automatic coord_t coord_of(input emesh_pkg::addr_t addr);
      return addr[emesh_pkg::ADDR_W-1 -: COORD_W];
   endfunction

endpackage

// File: source/emesh_if.sv
`timescale 1ns/1ps
//####################
// Mesh transaction hop
// Four-phase req/ack with the write fields
//####################
interface emesh_if;

   logic                 req;        // Fields valid, held until ack
   logic                 ack;        // Responder accepted
   emesh_pkg::addr_t     dstaddr;    // Destination
   emesh_pkg::addr_t     srcaddr;    // Originator
   emesh_pkg::data_t     data;       // Write data
   emesh_pkg::datamode_t datamode;   // Transfer size

   // Side that owns the transaction
   modport requester (
      output req, dstaddr, srcaddr, data, datamode,
      input  ack
   );

   // Side that accepts it
   modport responder (
      input  req, dstaddr, srcaddr, data, datamode,
      output ack
   );

endinterface

// File: source/host_slave_port.sv
`timescale 1ns/1ps
//####################
// Host slave port
// One-entry buffer from host writes onto the mesh
//####################
module host_slave_port (
   input  logic                 eclk,
   input  logic                 rst,
   input  logic                 host_req,
   output logic                 host_ack,
   input  emesh_pkg::addr_t     host_addr,
   input  emesh_pkg::data_t     host_data,
   input  emesh_pkg::datamode_t host_datamode,
   emesh_if.requester           mesh
);

   emesh_pkg::hs_state_t in_state;   // Host side handshake
   emesh_pkg::hs_state_t out_state;  // Mesh side handshake
   logic                 full;       // Buffer occupied
   logic                 capture;    // Take host fields this cycle
   emesh_pkg::addr_t     buf_addr;
   emesh_pkg::data_t     buf_data;
   emesh_pkg::datamode_t buf_mode;

   assign capture = (in_state == emesh_pkg::IDLE) && host_req && !full;

   //##################
   // Host side
   //##################
   always_ff @(posedge eclk) begin
      if (rst) begin
         in_state <= emesh_pkg::IDLE;
         host_ack <= 1'b0;
      end else begin
         case (in_state)
            emesh_pkg::IDLE: begin
               if (capture) begin
                  host_ack <= 1'b1;                  // Accept next cycle
                  in_state <= emesh_pkg::WAIT_DROP;
               end
            end
            emesh_pkg::WAIT_DROP: begin
               if (!host_req) begin
                  host_ack <= 1'b0;                  // Release after req falls
                  in_state <= emesh_pkg::IDLE;
               end
            end
            default: in_state <= emesh_pkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge eclk) begin
      if (capture) begin
         buf_addr <= host_addr;
         buf_data <= host_data;
         buf_mode <= host_datamode;
      end
   end

   //##################
   // Mesh side
   //##################
   always_ff @(posedge eclk) begin
      if (rst) begin
         out_state <= emesh_pkg::IDLE;
         mesh.req  <= 1'b0;
         full      <= 1'b0;
      end else begin
         if (capture)
            full <= 1'b1;
         case (out_state)
            emesh_pkg::IDLE: begin
               if (full) begin
                  mesh.req  <= 1'b1;                 // Present the buffer
                  out_state <= emesh_pkg::WAIT_ACK;
               end
            end
            emesh_pkg::WAIT_ACK: begin
               if (mesh.ack) begin
                  mesh.req  <= 1'b0;
                  out_state <= emesh_pkg::WAIT_DROP;
               end
            end
            emesh_pkg::WAIT_DROP: begin
               if (!mesh.ack) begin
                  full      <= 1'b0;                 // Slot free again
                  out_state <= emesh_pkg::IDLE;
               end
            end
            default: out_state <= emesh_pkg::IDLE;
         endcase
      end
   end

   assign mesh.dstaddr  = buf_addr;
   assign mesh.srcaddr  = memmap_pkg::HOST_SRCADDR;  // Replies go to the host
   assign mesh.data     = buf_data;
   assign mesh.datamode = buf_mode;

   // Req stays up with frozen fields until the arbiter path acks
   a_fields_stable: assert property (@(posedge eclk) disable iff (rst)
      mesh.req && !mesh.ack |=>
         mesh.req && $stable({mesh.dstaddr, mesh.data, mesh.datamode}));

endmodule

// File: source/link_rx_port.sv
`timescale 1ns/1ps
//####################
// Chip link receive port
// Buffers inbound chip writes, remaps ext mem addresses
//####################
module link_rx_port (
   input  logic                 eclk,
   input  logic                 rst,
   input  logic                 link_in_req,
   output logic                 link_in_ack,
   input  emesh_pkg::addr_t     link_in_dstaddr,
   input  emesh_pkg::addr_t     link_in_srcaddr,
   input  emesh_pkg::data_t     link_in_data,
   input  emesh_pkg::datamode_t link_in_datamode,
   emesh_if.requester           mesh
);

   emesh_pkg::hs_state_t in_state;   // Link side handshake
   emesh_pkg::hs_state_t out_state;  // Mesh side handshake
   logic                 full;
   logic                 capture;
   logic                 ext_mem;    // Chip view of external memory
   emesh_pkg::addr_t     remap_addr;
   emesh_pkg::addr_t     buf_dst;
   emesh_pkg::addr_t     buf_src;
   emesh_pkg::data_t     buf_data;
   emesh_pkg::datamode_t buf_mode;

   //##################
   // Address remap
   //##################
   // Host coordinate itself keeps region 8
   assign ext_mem =
      (memmap_pkg::region_of(link_in_dstaddr) == memmap_pkg::VIRT_EXT_MEM) &&
      (memmap_pkg::coord_of(link_in_dstaddr) != memmap_pkg::HOST_COORD);

   always_comb begin
      remap_addr = link_in_dstaddr;
      if (ext_mem)
         remap_addr[emesh_pkg::ADDR_W-1 -: memmap_pkg::REGION_W] =
            memmap_pkg::PHYS_EXT_MEM;                // Swap region nibble only
   end

   assign capture = (in_state == emesh_pkg::IDLE) && link_in_req && !full;

   //##################
   // Link side
   //##################
   always_ff @(posedge eclk) begin
      if (rst) begin
         in_state    <= emesh_pkg::IDLE;
         link_in_ack <= 1'b0;
      end else begin
         case (in_state)
            emesh_pkg::IDLE: begin
               if (capture) begin
                  link_in_ack <= 1'b1;
                  in_state    <= emesh_pkg::WAIT_DROP;
               end
            end
            emesh_pkg::WAIT_DROP: begin
               if (!link_in_req) begin
                  link_in_ack <= 1'b0;
                  in_state    <= emesh_pkg::IDLE;
               end
            end
            default: in_state <= emesh_pkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge eclk) begin
      if (capture) begin
         buf_dst  <= remap_addr;                     // Stored already remapped
         buf_src  <= link_in_srcaddr;
         buf_data <= link_in_data;
         buf_mode <= link_in_datamode;
      end
   end

   //##################
   // Mesh side
   //##################
   always_ff @(posedge eclk) begin
      if (rst) begin
         out_state <= emesh_pkg::IDLE;
         mesh.req  <= 1'b0;
         full      <= 1'b0;
      end else begin
         if (capture)
            full <= 1'b1;
         case (out_state)
            emesh_pkg::IDLE: begin
               if (full) begin
                  mesh.req  <= 1'b1;
                  out_state <= emesh_pkg::WAIT_ACK;
               end
            end
            emesh_pkg::WAIT_ACK: begin
               if (mesh.ack) begin
                  mesh.req  <= 1'b0;
                  out_state <= emesh_pkg::WAIT_DROP;
               end
            end
            emesh_pkg::WAIT_DROP: begin
               if (!mesh.ack) begin
                  full      <= 1'b0;
                  out_state <= emesh_pkg::IDLE;
               end
            end
            default: out_state <= emesh_pkg::IDLE;
         endcase
      end
   end

   assign mesh.dstaddr  = buf_dst;
   assign mesh.srcaddr  = buf_src;
   assign mesh.data     = buf_data;
   assign mesh.datamode = buf_mode;

   a_fields_stable: assert property (@(posedge eclk) disable iff (rst)
      mesh.req && !mesh.ack |=> mesh.req &&
         $stable({mesh.dstaddr, mesh.srcaddr, mesh.data, mesh.datamode}));

endmodule

// File: source/mesh_arbiter.sv
`timescale 1ns/1ps
//####################
// Mesh arbiter
// Round robin of host and link ports onto one bus
//####################
module mesh_arbiter (
   input  logic        eclk,
   input  logic        rst,
   emesh_if.responder  host_side,
   emesh_if.responder  link_side,
   emesh_if.requester  bus
);

   typedef enum logic [1:0] {
      ARB_IDLE = 2'd0,    // Bus free
      ARB_HOST = 2'd1,    // Host port owns the bus
      ARB_LINK = 2'd2     // Link port owns the bus
   } arb_state_t;

   arb_state_t state;
   logic       prio_link;  // Link wins the next tie
   logic       gnt_host;
   logic       gnt_link;

   assign gnt_host = (state == ARB_HOST);
   assign gnt_link = (state == ARB_LINK);

   //##################
   // Grant FSM
   //##################
   always_ff @(posedge eclk) begin
      if (rst) begin
         state     <= ARB_IDLE;
         prio_link <= 1'b0;                          // Host first after reset
      end else begin
         case (state)
            ARB_IDLE: begin
               if (host_side.req && (!link_side.req || !prio_link)) begin
                  state     <= ARB_HOST;
                  prio_link <= 1'b1;
               end else if (link_side.req) begin
                  state     <= ARB_LINK;
                  prio_link <= 1'b0;
               end
            end
            ARB_HOST: begin
               if (!host_side.req && !bus.ack)
                  state <= ARB_IDLE;                 // Full cycle done
            end
            ARB_LINK: begin
               if (!link_side.req && !bus.ack)
                  state <= ARB_IDLE;
            end
            default: state <= ARB_IDLE;
         endcase
      end
   end

   //##################
   // Bus mux
   //##################
   assign bus.req      = (gnt_host && host_side.req) || (gnt_link && link_side.req);
   assign bus.dstaddr  = gnt_link ? link_side.dstaddr  : host_side.dstaddr;
   assign bus.srcaddr  = gnt_link ? link_side.srcaddr  : host_side.srcaddr;
   assign bus.data     = gnt_link ? link_side.data     : host_side.data;
   assign bus.datamode = gnt_link ? link_side.datamode : host_side.datamode;

   assign host_side.ack = gnt_host && bus.ack;       // Ack back to owner only
   assign link_side.ack = gnt_link && bus.ack;

   a_one_grant: assert property (@(posedge eclk) disable iff (rst)
      !(gnt_host && gnt_link));

   // Dispatcher ack must never arrive with no owner to take it
   a_ack_owned: assert property (@(posedge eclk) disable iff (rst)
      bus.ack |-> gnt_host || gnt_link);

endmodule

// File: source/mesh_dispatch.sv
`timescale 1ns/1ps
//####################
// Mesh dispatcher
// Sends bus writes to ext memory or to the link transmitter
//####################
module mesh_dispatch (
   input  logic                 eclk,
   input  logic                 rst,
   emesh_if.responder           bus,
   output logic                 mem_req,
   input  logic                 mem_ack,
   output emesh_pkg::addr_t     mem_addr,
   output emesh_pkg::addr_t     mem_srcaddr,
   output emesh_pkg::data_t     mem_data,
   output emesh_pkg::datamode_t mem_datamode,
   output logic                 link_out_req,
   input  logic                 link_out_ack,
   output emesh_pkg::addr_t     link_out_dstaddr,
   output emesh_pkg::addr_t     link_out_srcaddr,
   output emesh_pkg::data_t     link_out_data,
   output emesh_pkg::datamode_t link_out_datamode
);

   emesh_pkg::hs_state_t state;
   logic                 is_mem;   // Decode of the bus address
   logic                 to_mem;   // Decode held for the cycle
   logic                 sel_ack;  // Ack of the chosen output
   logic                 take;
   emesh_pkg::addr_t     dst_q;
   emesh_pkg::addr_t     src_q;
   emesh_pkg::data_t     data_q;
   emesh_pkg::datamode_t mode_q;

   assign is_mem  = (memmap_pkg::region_of(bus.dstaddr) == memmap_pkg::PHYS_EXT_MEM);
   assign sel_ack = to_mem ? mem_ack : link_out_ack;
   assign take    = (state == emesh_pkg::IDLE) && bus.req;

   always_ff @(posedge eclk) begin
      if (take) begin
         to_mem <= is_mem;
         dst_q  <= bus.dstaddr;
         src_q  <= bus.srcaddr;
         data_q <= bus.data;
         mode_q <= bus.datamode;
      end
   end

   //##################
   // Handshake bridge
   //##################
   always_ff @(posedge eclk) begin
      if (rst) begin
         state        <= emesh_pkg::IDLE;
         mem_req      <= 1'b0;
         link_out_req <= 1'b0;
         bus.ack      <= 1'b0;
      end else begin
         case (state)
            emesh_pkg::IDLE: begin
               if (take) begin
                  mem_req      <= is_mem;            // Out req one cycle later
                  link_out_req <= !is_mem;
                  state        <= emesh_pkg::WAIT_ACK;
               end
            end
            emesh_pkg::WAIT_ACK: begin
               if (sel_ack) begin
                  mem_req      <= 1'b0;
                  link_out_req <= 1'b0;
                  bus.ack      <= 1'b1;              // Downstream took it
                  state        <= emesh_pkg::WAIT_DROP;
               end
            end
            emesh_pkg::WAIT_DROP: begin
               if (!sel_ack && !bus.req) begin
                  bus.ack <= 1'b0;                   // Both sides released
                  state   <= emesh_pkg::IDLE;
               end
            end
            default: state <= emesh_pkg::IDLE;
         endcase
      end
   end

   assign mem_addr          = dst_q;
   assign mem_srcaddr       = src_q;
   assign mem_data          = data_q;
   assign mem_datamode      = mode_q;
   assign link_out_dstaddr  = dst_q;
   assign link_out_srcaddr  = src_q;
   assign link_out_data     = data_q;
   assign link_out_datamode = mode_q;

   a_one_out: assert property (@(posedge eclk) disable iff (rst)
      !(mem_req && link_out_req));

endmodule

// File: source/emesh_router.sv
`timescale 1ns/1ps
//####################
// Mesh router top
// Host and link ports, arbiter and dispatcher
//####################
module emesh_router (
   input  logic                 eclk,
   input  logic                 rst,
   // Host write port
   input  logic                 host_req,
   output logic                 host_ack,
   input  emesh_pkg::addr_t     host_addr,
   input  emesh_pkg::data_t     host_data,
   input  emesh_pkg::datamode_t host_datamode,
   // Chip link receive
   input  logic                 link_in_req,
   output logic                 link_in_ack,
   input  emesh_pkg::addr_t     link_in_dstaddr,
   input  emesh_pkg::addr_t     link_in_srcaddr,
   input  emesh_pkg::data_t     link_in_data,
   input  emesh_pkg::datamode_t link_in_datamode,
   // External memory master
   output logic                 mem_req,
   input  logic                 mem_ack,
   output emesh_pkg::addr_t     mem_addr,
   output emesh_pkg::addr_t     mem_srcaddr,
   output emesh_pkg::data_t     mem_data,
   output emesh_pkg::datamode_t mem_datamode,
   // Chip link transmit
   output logic                 link_out_req,
   input  logic                 link_out_ack,
   output emesh_pkg::addr_t     link_out_dstaddr,
   output emesh_pkg::addr_t     link_out_srcaddr,
   output emesh_pkg::data_t     link_out_data,
   output emesh_pkg::datamode_t link_out_datamode
);

   emesh_if host_mesh ();   // Host port to arbiter
   emesh_if link_mesh ();   // Link port to arbiter
   emesh_if bus_mesh ();    // Shared bus to dispatcher

   //##################
   // Requesters
   //##################
   host_slave_port u_host (
      .eclk          (eclk),
      .rst           (rst),
      .host_req      (host_req),
      .host_ack      (host_ack),
      .host_addr     (host_addr),
      .host_data     (host_data),
      .host_datamode (host_datamode),
      .mesh          (host_mesh.requester)
   );

   link_rx_port u_link_rx (
      .eclk             (eclk),
      .rst              (rst),
      .link_in_req      (link_in_req),
      .link_in_ack      (link_in_ack),
      .link_in_dstaddr  (link_in_dstaddr),
      .link_in_srcaddr  (link_in_srcaddr),
      .link_in_data     (link_in_data),
      .link_in_datamode (link_in_datamode),
      .mesh             (link_mesh.requester)
   );

   //##################
   // Shared bus
   //##################
   mesh_arbiter u_arb (
      .eclk      (eclk),
      .rst       (rst),
      .host_side (host_mesh.responder),
      .link_side (link_mesh.responder),
      .bus       (bus_mesh.requester)
   );

   mesh_dispatch u_disp (
      .eclk              (eclk),
      .rst               (rst),
      .bus               (bus_mesh.responder),
      .mem_req           (mem_req),
      .mem_ack           (mem_ack),
      .mem_addr          (mem_addr),
      .mem_srcaddr       (mem_srcaddr),
      .mem_data          (mem_data),
      .mem_datamode      (mem_datamode),
      .link_out_req      (link_out_req),
      .link_out_ack      (link_out_ack),
      .link_out_dstaddr  (link_out_dstaddr),
      .link_out_srcaddr  (link_out_srcaddr),
      .link_out_data     (link_out_data),
      .link_out_datamode (link_out_datamode)
   );

endmodule

// File: dv/router_checker.sv
`timescale 1ns/1ps
//####################
// Router checker
// Matches delivered writes against per-source expected queues
//####################
module router_checker (
   input logic                 eclk,
   input logic                 rst,
   input logic                 mem_req,
   input logic                 mem_ack,
   input emesh_pkg::addr_t     mem_addr,
   input emesh_pkg::addr_t     mem_srcaddr,
   input emesh_pkg::data_t     mem_data,
   input emesh_pkg::datamode_t mem_datamode,
   input logic                 link_out_req,
   input logic                 link_out_ack,
   input emesh_pkg::addr_t     link_out_dstaddr,
   input emesh_pkg::addr_t     link_out_srcaddr,
   input emesh_pkg::data_t     link_out_data,
   input emesh_pkg::datamode_t link_out_datamode
);

   // Record layout is {to_mem, dst, src, data, mode}
   logic [98:0] host_q[$];         // Host writes, issue order
   logic [98:0] link_q[$];         // Link writes, issue order
   int          error_count = 0;
   int          delivered   = 0;

   task add_expected(input logic from_link, input logic to_mem,
                     input emesh_pkg::addr_t dst, input emesh_pkg::addr_t src,
                     input emesh_pkg::data_t data, input emesh_pkg::datamode_t mode);
      if (from_link)
         link_q.push_back({to_mem, dst, src, data, mode});
      else
         host_q.push_back({to_mem, dst, src, data, mode});
   endtask

   function int pending();
      return host_q.size() + link_q.size();
   endfunction

   // Only the head of each source may match to keep per-source order
   task match_delivery(input logic on_mem, input emesh_pkg::addr_t dst,
                       input emesh_pkg::addr_t src, input emesh_pkg::data_t data,
                       input emesh_pkg::datamode_t mode);
      logic [98:0] rec;
      rec = {on_mem, dst, src, data, mode};
      delivered++;
      if (host_q.size() != 0 && host_q[0] == rec) begin
         void'(host_q.pop_front());
      end else if (link_q.size() != 0 && link_q[0] == rec) begin
         void'(link_q.pop_front());
      end else begin
         error_count++;
         $display("error @%0t: unexpected %s write dst=%h src=%h data=%h mode=%0d",
                  $time, on_mem ? "mem" : "link_out", dst, src, data, mode);
      end
   endtask

   //##################
   // Output monitor
   //##################
   // Out req falls on the edge that sees ack, so req && ack shows once
   always @(posedge eclk) begin
      if (!rst) begin
         if (mem_req && link_out_req) begin
            error_count++;
            $display("error @%0t: mem_req and link_out_req high together", $time);
         end
         if (mem_req && mem_ack)
            match_delivery(1'b1, mem_addr, mem_srcaddr, mem_data, mem_datamode);
         if (link_out_req && link_out_ack)
            match_delivery(1'b0, link_out_dstaddr, link_out_srcaddr,
                           link_out_data, link_out_datamode);
      end
   end

endmodule

// File: dv/tb_emesh_router.sv
`timescale 1ns/1ps
//####################
// Router testbench
// Host and link writes, random-delay responders, reference model
//####################
module tb_emesh_router;

   localparam int          TIMEOUT = 1000;      // Cycles allowed per wait
   localparam int          N_MAX   = 40;        // Random writes per source
   localparam logic [15:0] SEED    = 16'd33046;

   typedef struct packed {
      logic                 to_mem;
      emesh_pkg::addr_t     dst;
      emesh_pkg::addr_t     src;
      emesh_pkg::data_t     data;
      emesh_pkg::datamode_t mode;
   } expect_t;

   logic                 eclk              = 1'b0;
   logic                 rst               = 1'b1;
   logic                 host_req          = 1'b0;
   logic                 host_ack;
   emesh_pkg::addr_t     host_addr         = '0;
   emesh_pkg::data_t     host_data         = '0;
   emesh_pkg::datamode_t host_datamode     = '0;
   logic                 link_in_req       = 1'b0;
   logic                 link_in_ack;
   emesh_pkg::addr_t     link_in_dstaddr   = '0;
   emesh_pkg::addr_t     link_in_srcaddr   = '0;
   emesh_pkg::data_t     link_in_data      = '0;
   emesh_pkg::datamode_t link_in_datamode  = '0;
   logic                 mem_req;
   logic                 mem_ack           = 1'b0;
   emesh_pkg::addr_t     mem_addr;
   emesh_pkg::addr_t     mem_srcaddr;
   emesh_pkg::data_t     mem_data;
   emesh_pkg::datamode_t mem_datamode;
   logic                 link_out_req;
   logic                 link_out_ack      = 1'b0;
   emesh_pkg::addr_t     link_out_dstaddr;
   emesh_pkg::addr_t     link_out_srcaddr;
   emesh_pkg::data_t     link_out_data;
   emesh_pkg::datamode_t link_out_datamode;

   logic [15:0] stim_lfsr  = SEED;   // Addresses and data
   logic [15:0] resp_lfsr  = SEED;   // Responder delays
   logic [31:0] resp_rand;
   logic        long_delay = 1'b0;   // Stretch responder delays
   int          mem_cnt    = 0;
   int          lout_cnt   = 0;
   int          tb_errors  = 0;
   int          tests_ok   = 0;
   int          err_mark   = 0;
   int          total;

   emesh_pkg::addr_t     h_dst [N_MAX];
   emesh_pkg::data_t     h_data[N_MAX];
   emesh_pkg::datamode_t h_mode[N_MAX];
   emesh_pkg::addr_t     l_dst [N_MAX];
   emesh_pkg::addr_t     l_src [N_MAX];
   emesh_pkg::data_t     l_data[N_MAX];
   emesh_pkg::datamode_t l_mode[N_MAX];

   always #50 eclk = ~eclk;          // 100 ns period

   emesh_router uut (.*);

   router_checker chk (.*);

   //##################
   // Random source
   //##################
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   task automatic draw(inout logic [15:0] st, input int nbits, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < nbits; i++) begin
         st = lfsr_step(st);
         v  = {v[30:0], st[0]};
      end
   endtask

   // Steer a raw address into one of the map regions
   function automatic emesh_pkg::addr_t shape_addr(input logic [1:0] sel,
                                                   input emesh_pkg::addr_t raw);
      emesh_pkg::addr_t a;
      a = raw;
      case (sel)
         2'd0: a[31:28] = memmap_pkg::PHYS_EXT_MEM;
         2'd1: begin
            a[31:28] = memmap_pkg::VIRT_EXT_MEM;
            if (a[31:20] == memmap_pkg::HOST_COORD)
               a[20] = ~a[20];                       // Stay off the host
         end
         2'd2: a[31:20] = memmap_pkg::HOST_COORD;
         default: ;
      endcase
      return a;
   endfunction

   //##################
   // Reference model
   //##################
   function automatic expect_t expected_of(input logic from_link,
                                           input emesh_pkg::addr_t dst,
                                           input emesh_pkg::addr_t src,
                                           input emesh_pkg::data_t data,
                                           input emesh_pkg::datamode_t mode);
      expect_t e;
      e.dst  = dst;
      e.src  = from_link ? src : memmap_pkg::HOST_SRCADDR;
      e.data = data;
      e.mode = mode;
      if (from_link && dst[31:28] == memmap_pkg::VIRT_EXT_MEM &&
          dst[31:20] != memmap_pkg::HOST_COORD)
         e.dst[31:28] = memmap_pkg::PHYS_EXT_MEM;    // Chip view to DRAM
      e.to_mem = (e.dst[31:28] == memmap_pkg::PHYS_EXT_MEM);
      return e;
   endfunction

   //##################
   // Responders
   //##################
   // Each edge of ack waits a random count after req changes
   always @(negedge eclk) begin
      if (rst) begin
         mem_ack      = 1'b0;
         link_out_ack = 1'b0;
         mem_cnt      = 0;
         lout_cnt     = 0;
      end else begin
         if (mem_req != mem_ack) begin
            if (mem_cnt > 0) begin
               mem_cnt--;
            end else begin
               mem_ack = mem_req;
               draw(resp_lfsr, long_delay ? 5 : 2, resp_rand);
               mem_cnt = resp_rand;
            end
         end
         if (link_out_req != link_out_ack) begin
            if (lout_cnt > 0) begin
               lout_cnt--;
            end else begin
               link_out_ack = link_out_req;
               draw(resp_lfsr, long_delay ? 5 : 2, resp_rand);
               lout_cnt = resp_rand;
            end
         end
      end
   end

   //##################
   // Stimulus tasks
   //##################
   task abort_run(input string why);
      $display("%s at %0t ns", why, $time);
      $display("Result: FAILED");
      $finish;
   endtask

   task automatic host_write(input emesh_pkg::addr_t addr, input emesh_pkg::data_t data,
                             input emesh_pkg::datamode_t mode);
      expect_t e;
      int      n;
      e = expected_of(1'b0, addr, '0, data, mode);
      chk.add_expected(1'b0, e.to_mem, e.dst, e.src, e.data, e.mode);
      host_addr     = addr;
      host_data     = data;
      host_datamode = mode;
      host_req      = 1'b1;
      n = 0;
      while (host_ack !== 1'b1) begin
         @(negedge eclk);
         n++;
         if (n > TIMEOUT)
            abort_run("host_ack never rose");
      end
      host_req = 1'b0;
      n = 0;
      while (host_ack !== 1'b0) begin
         @(negedge eclk);
         n++;
         if (n > TIMEOUT)
            abort_run("host_ack never fell");
      end
   endtask

   task automatic link_write(input emesh_pkg::addr_t dst, input emesh_pkg::addr_t src,
                             input emesh_pkg::data_t data, input emesh_pkg::datamode_t mode);
      expect_t e;
      int      n;
      e = expected_of(1'b1, dst, src, data, mode);
      chk.add_expected(1'b1, e.to_mem, e.dst, e.src, e.data, e.mode);
      link_in_dstaddr  = dst;
      link_in_srcaddr  = src;
      link_in_data     = data;
      link_in_datamode = mode;
      link_in_req      = 1'b1;
      n = 0;
      while (link_in_ack !== 1'b1) begin
         @(negedge eclk);
         n++;
         if (n > TIMEOUT)
            abort_run("link_in_ack never rose");
      end
      link_in_req = 1'b0;
      n = 0;
      while (link_in_ack !== 1'b0) begin
         @(negedge eclk);
         n++;
         if (n > TIMEOUT)
            abort_run("link_in_ack never fell");
      end
   endtask

   task automatic make_traffic(input int n);
      logic [31:0] sel;
      logic [31:0] raw;
      for (int i = 0; i < n; i++) begin
         draw(stim_lfsr, 2, sel);
         draw(stim_lfsr, 32, raw);
         h_dst[i] = shape_addr(sel[1:0], raw);
         draw(stim_lfsr, 32, raw);
         h_data[i] = raw;
         draw(stim_lfsr, 2, raw);
         h_mode[i] = raw[1:0];
         draw(stim_lfsr, 2, sel);
         draw(stim_lfsr, 32, raw);
         l_dst[i] = shape_addr(sel[1:0], raw);
         draw(stim_lfsr, 32, raw);
         l_src[i] = raw;
         draw(stim_lfsr, 32, raw);
         l_data[i] = raw;
         draw(stim_lfsr, 2, raw);
         l_mode[i] = raw[1:0];
      end
   endtask

   // Host and link streams side by side
   task automatic run_both(input int n);
      fork
         begin
            for (int i = 0; i < n; i++)
               host_write(h_dst[i], h_data[i], h_mode[i]);
         end
         begin
            for (int j = 0; j < n; j++)
               link_write(l_dst[j], l_src[j], l_data[j], l_mode[j]);
         end
      join
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (chk.pending() != 0) begin
         @(negedge eclk);
         n++;
         if (n > TIMEOUT)
            abort_run("expected writes never reached an output");
      end
   endtask

   task automatic check_idle(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         if ({host_ack, link_in_ack, mem_req, link_out_req} !== 4'b0000) begin
            tb_errors++;
            $display("error @%0t: handshake output high after reset", $time);
         end
         @(negedge eclk);
      end
   endtask

   task automatic end_test(input string name);
      int errs;
      errs = chk.error_count + tb_errors - err_mark;
      if (errs == 0)
         tests_ok++;
      $display("test %s: %0d errors", name, errs);
      err_mark = chk.error_count + tb_errors;
   endtask

   //##################
   // Test sequence
   //##################
   initial begin
      repeat (5) @(negedge eclk);                    // Reset over 5 cycles
      rst = 1'b0;
      check_idle(4);
      end_test("reset_idle");

      host_write(32'h3000_1000, 32'hA5A5_0001, 2'd2);
      host_write(32'h8100_0040, 32'h0000_BEEF, 2'd0);
      host_write(32'h8450_0000, 32'h1357_9BDF, 2'd1);
      host_write(32'h1234_5678, 32'hFFFF_0000, 2'd3);
      drain();
      end_test("host_writes");

      link_write(32'h8450_0010, 32'h8450_0000, 32'hC0DE_0001, 2'd2);  // Remapped
      link_write(32'h8100_0020, 32'h8200_0000, 32'hC0DE_0002, 2'd2);  // Host coord
      link_write(32'h3000_0004, 32'h8450_0000, 32'hC0DE_0003, 2'd1);
      link_write(32'h5000_0000, 32'h8450_0000, 32'hC0DE_0004, 2'd0);
      drain();
      end_test("link_remap");

      make_traffic(N_MAX);
      run_both(N_MAX);
      drain();
      end_test("random_both");

      long_delay = 1'b1;
      make_traffic(12);
      run_both(12);
      drain();
      end_test("long_delays");

      total = chk.error_count + tb_errors;
      $display("tests=5 ok=%0d delivered=%0d errors=%0d", tests_ok, chk.delivered, total);
      if (total == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// File: emesh_router.f
source/emesh_pkg.sv
source/memmap_pkg.sv
source/emesh_if.sv
source/host_slave_port.sv
source/link_rx_port.sv
source/mesh_arbiter.sv
source/mesh_dispatch.sv
source/emesh_router.sv
dv/router_checker.sv
dv/tb_emesh_router.sv

// File: Bender.yml
package:
  name: emesh_router

sources:
  - source/emesh_pkg.sv
  - source/memmap_pkg.sv
  - source/emesh_if.sv
  - source/host_slave_port.sv
  - source/link_rx_port.sv
  - source/mesh_arbiter.sv
  - source/mesh_dispatch.sv
  - source/emesh_router.sv
  - target: simulation
    files:
      - dv/router_checker.sv
      - dv/tb_emesh_router.sv
